// ==== source/usb_proxy_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// USB proxy shared definitions
// Widths, token PIDs, register map, FSM states and the beat, config
// and capture record structs used across the proxy
//////////////////////////////////////////////////////////////////////

package usb_proxy_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  pid_t;
    typedef logic [6:0]  dev_addr_t;
    typedef logic [31:0] timestamp_t;
    typedef logic [31:0] pkt_cnt_t;
    typedef logic [15:0] err_cnt_t;
    typedef logic [7:0]  reg_addr_t;

    // Token PIDs that carry a device address
    localparam pid_t PID_OUT   = 4'b0001;
    localparam pid_t PID_IN    = 4'b1001;
    localparam pid_t PID_SETUP = 4'b1101;

    localparam byte_t ADDR_BYTE_INDEX = 8'd1;   // Sop beat is index 0

    //////////////////////////////////////////////////////////////////////
    // Readback register map
    //////////////////////////////////////////////////////////////////////
    localparam reg_addr_t REG_STATUS    = 8'h00;
    localparam reg_addr_t REG_ERR_LO    = 8'h01;  // Two bytes, little-endian
    localparam reg_addr_t REG_HOST_CNT0 = 8'h03;  // Four bytes
    localparam reg_addr_t REG_DEV_CNT0  = 8'h07;  // Four bytes

    typedef enum logic {
        DIR_HOST_TO_DEVICE = 1'b0,
        DIR_DEVICE_TO_HOST = 1'b1
    } dir_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOST_TO_DEVICE,
        ST_WAIT_DEVICE_RESP,
        ST_DEVICE_TO_HOST,
        ST_WAIT_HOST_RESP
    } proxy_state_e;

    // One decoded byte beat of a packet
    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sop;
        logic  eop;
        pid_t  pid;
        logic  crc_ok;   // Only meaningful on eop
    } usb_beat_t;

    typedef struct packed {
        logic      proxy_enable;
        logic      translate_enable;
        dev_addr_t translate_from;
        dev_addr_t translate_to;
    } proxy_cfg_t;

    typedef struct packed {
        byte_t      data;
        pid_t       pid;
        dir_e       dir;
        logic       translated;
        timestamp_t ts;          // Start time of the packet
    } capture_rec_t;

endpackage

// ==== source/proxy_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Proxy transaction FSM
// Lets one direction forward at a time and tracks the response wait
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module proxy_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  usb_proxy_pkg::usb_beat_t host_rx,
    input  usb_proxy_pkg::usb_beat_t device_rx,
    input  logic                    proxy_enable,
    input  logic                    expired,
    output logic                    fwd_h2d,
    output logic                    fwd_d2h,
    output logic                    wait_active
);

    import usb_proxy_pkg::*;

    proxy_state_e state;
    proxy_state_e state_nxt;

    logic host_sop;
    logic host_eop;
    logic dev_sop;
    logic dev_eop;

    assign host_sop = host_rx.valid && host_rx.sop;
    assign host_eop = host_rx.valid && host_rx.eop;
    assign dev_sop  = device_rx.valid && device_rx.sop;
    assign dev_eop  = device_rx.valid && device_rx.eop;

    // Accepting sop ends the wait, so the next wait starts a fresh count
    assign wait_active = (state == ST_WAIT_DEVICE_RESP && !dev_sop) ||
                         (state == ST_WAIT_HOST_RESP && !host_sop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state and forwarding enables
    //////////////////////////////////////////////////////////////////////
    // A packet accepted on a single sop+eop beat goes straight to the wait
    always_comb begin
        state_nxt = state;
        fwd_h2d   = 1'b0;
        fwd_d2h   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (proxy_enable && host_sop) begin       // Host wins a tie
                    fwd_h2d   = 1'b1;
                    state_nxt = host_eop ? ST_WAIT_DEVICE_RESP : ST_HOST_TO_DEVICE;
                end else if (proxy_enable && dev_sop) begin
                    fwd_d2h   = 1'b1;
                    state_nxt = dev_eop ? ST_WAIT_HOST_RESP : ST_DEVICE_TO_HOST;
                end
            end
            ST_HOST_TO_DEVICE: begin
                fwd_h2d = 1'b1;
                if (host_eop) begin
                    state_nxt = ST_WAIT_DEVICE_RESP;
                end
            end
            ST_WAIT_DEVICE_RESP: begin
                if (dev_sop) begin                        // Host beats dropped here
                    fwd_d2h   = 1'b1;
                    state_nxt = dev_eop ? ST_WAIT_HOST_RESP : ST_DEVICE_TO_HOST;
                end else if (expired) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_DEVICE_TO_HOST: begin
                fwd_d2h = 1'b1;
                if (dev_eop) begin
                    state_nxt = ST_WAIT_HOST_RESP;
                end
            end
            ST_WAIT_HOST_RESP: begin
                if (host_sop) begin
                    fwd_h2d   = 1'b1;
                    state_nxt = host_eop ? ST_WAIT_DEVICE_RESP : ST_HOST_TO_DEVICE;
                end else if (expired) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Only one direction may ever own the bus
    a_one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(fwd_h2d && fwd_d2h));

endmodule

// ==== source/resp_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Response wait timer
// Counts cycles in a wait state and flags when the wait has run out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module resp_timer #(
    parameter int RESP_TIMEOUT = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wait_active,
    output logic expired
);

    localparam int CNT_W = $clog2(RESP_TIMEOUT + 1);

    logic [CNT_W-1:0] cnt;   // Cycles since entry to the wait
    logic             at_limit;

    assign at_limit = (cnt == CNT_W'(RESP_TIMEOUT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!wait_active) begin
            cnt <= '0;
        end else if (!at_limit) begin
            cnt <= cnt + 1'b1;            // Holds at the limit
        end
    end

    assign expired = wait_active && at_limit;

    // Expiry needs an unbroken wait of RESP_TIMEOUT cycles behind it
    a_full_wait: assert property (@(posedge clk) disable iff (!rst_n)
        expired |-> $past(wait_active, RESP_TIMEOUT));

endmodule

// ==== source/pkt_forward.sv ====
//////////////////////////////////////////////////////////////////////
// Beat forwarding path
// Registers enabled beats onto the opposite tx port with one cycle of
// latency and rewrites the device address of host token packets
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pkt_forward (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_proxy_pkg::usb_beat_t  host_rx,
    input  usb_proxy_pkg::usb_beat_t  device_rx,
    input  logic                     fwd_h2d,
    input  logic                     fwd_d2h,
    input  usb_proxy_pkg::proxy_cfg_t cfg,
    output usb_proxy_pkg::usb_beat_t  host_tx,
    output usb_proxy_pkg::usb_beat_t  device_tx,
    output logic                     fwd_beat,
    output logic                     fwd_sop,
    output logic                     translated,
    output usb_proxy_pkg::dir_e       fwd_dir
);

    import usb_proxy_pkg::*;

    logic      h_fwd;
    logic      d_fwd;
    byte_t     h_idx;       // Index of the next host beat
    logic      h_token;     // Current host packet began with a token PID
    logic      do_xlate;
    usb_beat_t h_beat;

    assign h_fwd = fwd_h2d && host_rx.valid;
    assign d_fwd = fwd_d2h && device_rx.valid;

    //////////////////////////////////////////////////////////////////////
    // Host packet position and address translation
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_idx   <= '0;
            h_token <= 1'b0;
        end else if (h_fwd) begin
            if (host_rx.sop) begin
                h_idx   <= 8'd1;
                h_token <= host_rx.pid inside {PID_OUT, PID_IN, PID_SETUP};
            end else if (h_idx != 8'hFF) begin
                h_idx <= h_idx + 1'b1;          // Saturates at 255
            end
        end
    end

    assign do_xlate = cfg.translate_enable && h_token && !host_rx.sop &&
                      (h_idx == ADDR_BYTE_INDEX) &&
                      (host_rx.data[6:0] == cfg.translate_from);

    always_comb begin
        h_beat = host_rx;
        if (do_xlate) begin
            h_beat.data[6:0] = cfg.translate_to;  // Bit 7 kept
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            device_tx  <= '0;
            host_tx    <= '0;
            fwd_beat   <= 1'b0;
            fwd_sop    <= 1'b0;
            translated <= 1'b0;
            fwd_dir    <= DIR_HOST_TO_DEVICE;
        end else begin
            device_tx  <= h_fwd ? h_beat : '0;  // Idle port drives all zero
            host_tx    <= d_fwd ? device_rx : '0;
            fwd_beat   <= h_fwd || d_fwd;
            fwd_sop    <= (h_fwd && host_rx.sop) || (d_fwd && device_rx.sop);
            translated <= h_fwd && do_xlate;
            fwd_dir    <= d_fwd ? DIR_DEVICE_TO_HOST : DIR_HOST_TO_DEVICE;
        end
    end

    // A tx sop is a valid beat that was an accepted rx sop one cycle back
    a_dev_sop: assert property (@(posedge clk) disable iff (!rst_n)
        device_tx.sop |-> device_tx.valid && $past(fwd_h2d && host_rx.sop));
    a_host_sop: assert property (@(posedge clk) disable iff (!rst_n)
        host_tx.sop |-> host_tx.valid && $past(fwd_d2h && device_rx.sop));

endmodule

// ==== source/capture_log.sv ====
//////////////////////////////////////////////////////////////////////
// Capture record builder
// Tags every forwarded beat with direction, PID and packet start time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module capture_log (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fwd_beat,
    input  logic                       fwd_sop,
    input  usb_proxy_pkg::dir_e         fwd_dir,
    input  logic                       translated,
    input  usb_proxy_pkg::usb_beat_t    host_tx,
    input  usb_proxy_pkg::usb_beat_t    device_tx,
    input  usb_proxy_pkg::timestamp_t   timestamp,
    output logic                       cap_strobe,
    output usb_proxy_pkg::capture_rec_t cap_rec
);

    import usb_proxy_pkg::*;

    timestamp_t pkt_ts;    // Start time of the packet in flight
    usb_beat_t  tx_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_ts <= '0;
        end else if (fwd_sop) begin
            pkt_ts <= timestamp;
        end
    end

    // Device-to-host beats leave on the host port
    assign tx_sel = (fwd_dir == DIR_DEVICE_TO_HOST) ? host_tx : device_tx;

    // Record goes out alongside the tx beat
    assign cap_strobe         = fwd_beat;
    assign cap_rec.data       = tx_sel.data;
    assign cap_rec.pid        = tx_sel.pid;
    assign cap_rec.dir        = fwd_dir;
    assign cap_rec.translated = translated;
    assign cap_rec.ts         = fwd_sop ? timestamp : pkt_ts;  // Sop uses live time

endmodule

// ==== source/stat_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Statistics and status registers
// Counts forwarded packets per direction and CRC errors, tracks link
// state, and serves byte-wide readback by address
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module stat_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_proxy_pkg::usb_beat_t  host_rx,
    input  usb_proxy_pkg::usb_beat_t  device_rx,
    input  logic                     fwd_sop,
    input  usb_proxy_pkg::dir_e       fwd_dir,
    input  usb_proxy_pkg::proxy_cfg_t cfg,
    input  logic [1:0]               device_line_state,
    input  usb_proxy_pkg::reg_addr_t  reg_addr,
    output usb_proxy_pkg::byte_t      reg_rdata
);

    import usb_proxy_pkg::*;

    pkt_cnt_t host_cnt;
    pkt_cnt_t dev_cnt;
    err_cnt_t err_cnt;
    logic     connected;
    logic     err_seen;
    logic     host_err;
    logic     dev_err;
    byte_t    status;

    // Any bad eop counts, forwarded or not
    assign host_err = host_rx.valid && host_rx.eop && !host_rx.crc_ok;
    assign dev_err  = device_rx.valid && device_rx.eop && !device_rx.crc_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_cnt  <= '0;
            dev_cnt   <= '0;
            err_cnt   <= '0;
            connected <= 1'b0;
            err_seen  <= 1'b0;
        end else begin
            if (fwd_sop && fwd_dir == DIR_HOST_TO_DEVICE) begin
                host_cnt <= host_cnt + 1'b1;
            end
            if (fwd_sop && fwd_dir == DIR_DEVICE_TO_HOST) begin
                dev_cnt <= dev_cnt + 1'b1;
            end
            err_cnt   <= err_cnt + err_cnt_t'(host_err) + err_cnt_t'(dev_err);
            connected <= (device_line_state != 2'b00);
            if (host_err || dev_err) begin
                err_seen <= 1'b1;            // Sticky until reset
            end
        end
    end

    assign status = {4'b0000, cfg.translate_enable, cfg.proxy_enable, err_seen, connected};

    //////////////////////////////////////////////////////////////////////
    // Readback mux, counters little-endian by byte
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (reg_addr)
            REG_STATUS:            reg_rdata = status;
            REG_ERR_LO:            reg_rdata = err_cnt[7:0];
            REG_ERR_LO + 8'd1:     reg_rdata = err_cnt[15:8];
            REG_HOST_CNT0:         reg_rdata = host_cnt[7:0];
            REG_HOST_CNT0 + 8'd1:  reg_rdata = host_cnt[15:8];
            REG_HOST_CNT0 + 8'd2:  reg_rdata = host_cnt[23:16];
            REG_HOST_CNT0 + 8'd3:  reg_rdata = host_cnt[31:24];
            REG_DEV_CNT0:          reg_rdata = dev_cnt[7:0];
            REG_DEV_CNT0 + 8'd1:   reg_rdata = dev_cnt[15:8];
            REG_DEV_CNT0 + 8'd2:   reg_rdata = dev_cnt[23:16];
            REG_DEV_CNT0 + 8'd3:   reg_rdata = dev_cnt[31:24];
            default:               reg_rdata = 8'h00;
        endcase
    end

endmodule

// ==== source/usb_proxy_top.sv ====
//////////////////////////////////////////////////////////////////////
// USB packet proxy and monitor
// Forwards decoded packets between host and device one direction at
// a time, with address translation, capture output and statistics
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module usb_proxy_top #(
    parameter int RESP_TIMEOUT = 16    // Response wait in clk cycles
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  usb_proxy_pkg::usb_beat_t    host_rx,
    input  usb_proxy_pkg::usb_beat_t    device_rx,
    output usb_proxy_pkg::usb_beat_t    host_tx,
    output usb_proxy_pkg::usb_beat_t    device_tx,
    input  usb_proxy_pkg::proxy_cfg_t   cfg,
    input  usb_proxy_pkg::timestamp_t   timestamp,
    input  logic [1:0]                 device_line_state,
    input  usb_proxy_pkg::reg_addr_t    reg_addr,
    output usb_proxy_pkg::byte_t        reg_rdata,
    output logic                       cap_strobe,
    output usb_proxy_pkg::capture_rec_t cap_rec
);

    import usb_proxy_pkg::*;

    logic fwd_h2d;
    logic fwd_d2h;
    logic wait_active;
    logic expired;
    logic fwd_beat;
    logic fwd_sop;
    logic translated;
    dir_e fwd_dir;

    //////////////////////////////////////////////////////////////////////
    // Transaction control
    //////////////////////////////////////////////////////////////////////
    proxy_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_rx      (host_rx),
        .device_rx    (device_rx),
        .proxy_enable (cfg.proxy_enable),
        .expired      (expired),
        .fwd_h2d      (fwd_h2d),
        .fwd_d2h      (fwd_d2h),
        .wait_active  (wait_active)
    );

    resp_timer #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wait_active (wait_active),
        .expired     (expired)
    );

    //////////////////////////////////////////////////////////////////////
    // Data path, capture and statistics
    //////////////////////////////////////////////////////////////////////
    pkt_forward u_fwd (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_rx    (host_rx),
        .device_rx  (device_rx),
        .fwd_h2d    (fwd_h2d),
        .fwd_d2h    (fwd_d2h),
        .cfg        (cfg),
        .host_tx    (host_tx),
        .device_tx  (device_tx),
        .fwd_beat   (fwd_beat),
        .fwd_sop    (fwd_sop),
        .translated (translated),
        .fwd_dir    (fwd_dir)
    );

    capture_log u_cap (
        .clk        (clk),
        .rst_n      (rst_n),
        .fwd_beat   (fwd_beat),
        .fwd_sop    (fwd_sop),
        .fwd_dir    (fwd_dir),
        .translated (translated),
        .host_tx    (host_tx),
        .device_tx  (device_tx),
        .timestamp  (timestamp),
        .cap_strobe (cap_strobe),
        .cap_rec    (cap_rec)
    );

    stat_regs u_stats (
        .clk               (clk),
        .rst_n             (rst_n),
        .host_rx           (host_rx),
        .device_rx         (device_rx),
        .fwd_sop           (fwd_sop),
        .fwd_dir           (fwd_dir),
        .cfg               (cfg),
        .device_line_state (device_line_state),
        .reg_addr          (reg_addr),
        .reg_rdata         (reg_rdata)
    );

endmodule

// ==== tb/tb_usb_proxy.sv ====
//////////////////////////////////////////////////////////////////////
// USB proxy testbench
// Random host and device packets against a packet-level model of the
// transaction rules, with beat, capture and readback checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_usb_proxy;

    import usb_proxy_pkg::*;

    localparam int RESP_TIMEOUT = 16;
    localparam int NUM_PKTS     = 300;
    localparam int QUIET_LIMIT  = 50;   // Cycles allowed for the tx ports to drain

    logic         clk;
    logic         rst_n;
    usb_beat_t    host_rx;
    usb_beat_t    device_rx;
    usb_beat_t    host_tx;
    usb_beat_t    device_tx;
    proxy_cfg_t   cfg;
    timestamp_t   timestamp;
    logic [1:0]   device_line_state;
    reg_addr_t    reg_addr;
    byte_t        reg_rdata;
    logic         cap_strobe;
    capture_rec_t cap_rec;

    // Values applied at the next falling edge
    proxy_cfg_t   cfg_next;
    logic [1:0]   line_next;
    reg_addr_t    addr_next;

    // Reference model
    int unsigned  cyc;            // Also driven as the timestamp
    proxy_state_e m_state;
    int unsigned  wait_entry;     // First cycle spent in the wait state
    pkt_cnt_t     m_host_cnt;
    pkt_cnt_t     m_dev_cnt;
    err_cnt_t     m_err_cnt;
    timestamp_t   m_pkt_ts;
    usb_beat_t    exp_host_tx;
    usb_beat_t    exp_dev_tx;
    logic         exp_strobe;
    logic         exp_sop;
    capture_rec_t exp_cap;

    int           errors;
    int           checks;
    logic         quiet;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    usb_proxy_top #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .host_rx           (host_rx),
        .device_rx         (device_rx),
        .host_tx           (host_tx),
        .device_tx         (device_tx),
        .cfg               (cfg),
        .timestamp         (timestamp),
        .device_line_state (device_line_state),
        .reg_addr          (reg_addr),
        .reg_rdata         (reg_rdata),
        .cap_strobe        (cap_strobe),
        .cap_rec           (cap_rec)
    );

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_beat(input string name, input usb_beat_t got, input usb_beat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    task automatic check_capture(input string name, input capture_rec_t got,
                                 input capture_rec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    task automatic check_reg(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One clock of stimulus, checking the beat driven a cycle earlier
    //////////////////////////////////////////////////////////////////////
    task automatic run_cycle(input usb_beat_t hb, input usb_beat_t db, input logic fwd,
                             input dir_e dir, input usb_beat_t tx, input logic xl);
        @(negedge clk);
        cyc++;
        host_rx           = hb;
        device_rx         = db;
        cfg               = cfg_next;
        device_line_state = line_next;
        reg_addr          = addr_next;
        timestamp         = timestamp_t'(cyc);
        #5;
        check_beat("host_tx", host_tx, exp_host_tx);
        check_beat("device_tx", device_tx, exp_dev_tx);
        check_bit("cap_strobe", cap_strobe, exp_strobe);
        if (exp_strobe) begin
            if (exp_sop) begin
                m_pkt_ts = timestamp_t'(cyc);   // Time of the first output beat
            end
            exp_cap.ts = m_pkt_ts;
            check_capture("cap_rec", cap_rec, exp_cap);
        end
        exp_host_tx        = (fwd && dir == DIR_DEVICE_TO_HOST) ? tx : '0;
        exp_dev_tx         = (fwd && dir == DIR_HOST_TO_DEVICE) ? tx : '0;
        exp_strobe         = fwd;
        exp_sop            = fwd && tx.sop;
        exp_cap.data       = tx.data;
        exp_cap.pid        = tx.pid;
        exp_cap.dir        = dir;
        exp_cap.translated = xl;
        if (hb.valid && hb.eop && !hb.crc_ok) m_err_cnt++;
        if (db.valid && db.eop && !db.crc_ok) m_err_cnt++;
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle('0, '0, 1'b0, DIR_HOST_TO_DEVICE, '0, 1'b0);
    endtask

    function automatic proxy_cfg_t random_cfg();
        proxy_cfg_t c;
        c.proxy_enable     = ($urandom_range(7, 0) != 0);
        c.translate_enable = $urandom_range(1, 0);
        c.translate_from   = dev_addr_t'($urandom_range(127, 0));
        c.translate_to     = dev_addr_t'($urandom_range(127, 0));
        return c;
    endfunction

    task automatic send_packet(input logic from_host, input int len);
        usb_beat_t b;
        usb_beat_t tx;
        pid_t      pid;
        logic      token;
        logic      accept;
        logic      xl;
        dir_e      dir;
        if ($urandom_range(1, 0) == 1) begin
            case ($urandom_range(2, 0))
                0:       pid = PID_OUT;
                1:       pid = PID_IN;
                default: pid = PID_SETUP;
            endcase
        end else begin
            pid = pid_t'($urandom_range(15, 0));
        end
        token = (pid == PID_OUT) || (pid == PID_IN) || (pid == PID_SETUP);
        // A wait that ran out during the gap has already fallen back to idle
        if ((m_state == ST_WAIT_DEVICE_RESP || m_state == ST_WAIT_HOST_RESP) &&
            (cyc + 1 - wait_entry > RESP_TIMEOUT)) begin
            m_state = ST_IDLE;
        end
        if (from_host) begin
            accept = (m_state == ST_IDLE && cfg_next.proxy_enable) ||
                     (m_state == ST_WAIT_HOST_RESP);
            dir    = DIR_HOST_TO_DEVICE;
        end else begin
            accept = (m_state == ST_IDLE && cfg_next.proxy_enable) ||
                     (m_state == ST_WAIT_DEVICE_RESP);
            dir    = DIR_DEVICE_TO_HOST;
        end
        for (int i = 0; i < len; i++) begin
            b        = '0;
            b.valid  = 1'b1;
            b.sop    = (i == 0);
            b.eop    = (i == len - 1);
            b.pid    = pid;
            b.data   = byte_t'($urandom_range(255, 0));
            if (i == 1 && token && $urandom_range(9, 0) < 7) begin
                b.data[6:0] = cfg_next.translate_from;   // Bias toward a match
            end
            b.crc_ok = !(b.eop && $urandom_range(7, 0) == 0);
            tx       = b;
            xl       = from_host && token && (i == 1) && cfg_next.translate_enable &&
                       (b.data[6:0] == cfg_next.translate_from);
            if (xl) begin
                tx.data[6:0] = cfg_next.translate_to;
            end
            if (from_host) begin
                run_cycle(b, '0, accept, dir, tx, xl);
            end else begin
                run_cycle('0, b, accept, dir, tx, 1'b0);
            end
        end
        if (accept) begin
            m_state    = from_host ? ST_WAIT_DEVICE_RESP : ST_WAIT_HOST_RESP;
            wait_entry = cyc + 1;
            if (from_host) m_host_cnt++;
            else m_dev_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////
    function automatic byte_t reg_expect(input reg_addr_t a);
        byte_t r;
        r = 8'h00;
        if (a == 8'h00) begin
            r[0] = (device_line_state != 2'b00);
            r[1] = (m_err_cnt != 0);
            r[2] = cfg.proxy_enable;
            r[3] = cfg.translate_enable;
        end else if (a <= 8'h02) begin
            r = byte_t'(m_err_cnt >> (8 * (a - 8'h01)));
        end else if (a <= 8'h06) begin
            r = byte_t'(m_host_cnt >> (8 * (a - 8'h03)));
        end else if (a <= 8'h0A) begin
            r = byte_t'(m_dev_cnt >> (8 * (a - 8'h07)));
        end
        return r;
    endfunction

    task automatic read_all_regs();
        for (int a = 0; a < 16; a++) begin
            addr_next = reg_addr_t'(a);
            idle(1);
            check_reg($sformatf("reg_rdata[%02h]", a), reg_rdata, reg_expect(reg_addr_t'(a)));
        end
    endtask

    task automatic wait_quiet(output logic done);
        int n;
        n = 0;
        idle(1);
        while ((host_tx.valid || device_tx.valid || cap_strobe) && n < QUIET_LIMIT) begin
            idle(1);
            n++;
        end
        done = !(host_tx.valid || device_tx.valid || cap_strobe);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h0cb33c99));
        rst_n             = 1'b0;
        host_rx           = '0;
        device_rx         = '0;
        cfg               = '0;
        timestamp         = '0;
        device_line_state = 2'b00;
        reg_addr          = '0;
        cfg_next          = '0;
        line_next         = 2'b00;
        addr_next         = '0;
        cyc               = 0;
        m_state           = ST_IDLE;
        wait_entry        = 0;
        m_host_cnt        = '0;
        m_dev_cnt         = '0;
        m_err_cnt         = '0;
        m_pkt_ts          = '0;
        exp_host_tx       = '0;
        exp_dev_tx        = '0;
        exp_strobe        = 1'b0;
        exp_sop           = 1'b0;
        exp_cap           = '0;
        errors            = 0;
        checks            = 0;
        quiet             = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle(3);
        read_all_regs();           // All zero out of reset

        line_next = 2'($urandom_range(3, 0));
        cfg_next  = random_cfg();
        for (int p = 0; p < NUM_PKTS; p++) begin
            if ($urandom_range(7, 0) == 0) begin
                cfg_next = random_cfg();
            end
            send_packet($urandom_range(1, 0), $urandom_range(8, 1));
            if ($urandom_range(3, 0) == 0) begin
                idle($urandom_range(40, 25));    // Long enough for any wait to expire
            end else begin
                idle($urandom_range(9, 0));
            end
        end

        wait_quiet(quiet);
        if (quiet) begin
            read_all_regs();
        end else begin
            errors++;
            $display("Timeout: tx ports still active after %0d idle cycles", QUIET_LIMIT);
        end

        $display("checks: %0d  errors: %0d  host pkts: %0d  device pkts: %0d  crc errors: %0d",
                 checks, errors, m_host_cnt, m_dev_cnt, m_err_cnt);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/usb_proxy_pkg.sv
source/proxy_fsm.sv
source/resp_timer.sv
source/pkt_forward.sv
source/capture_log.sv
source/stat_regs.sv
source/usb_proxy_top.sv
tb/tb_usb_proxy.sv
